//--- src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////

  // one word per bus beat, four beats fill a line
  localparam int XLEN       = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_BITS  = XLEN * LINE_WORDS;
  localparam int SETS       = 64;
  localparam int IDX_BITS   = 6;
  localparam int WORD_BITS  = 2;
  // whatever is left above index, word and byte offset
  localparam int TAG_BITS   = XLEN - IDX_BITS - WORD_BITS - 2;

  //////////////////////////////////////////////////////////////////////
  // address views
  //////////////////////////////////////////////////////////////////////

  // field view of a byte address, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]  tag;
    logic [IDX_BITS-1:0]  idx;
    logic [WORD_BITS-1:0] word;
    logic [1:0]           byte_off;
  } addr_s;

  // flat word for the ports, fields for the lookup
  typedef union packed {
    logic [XLEN-1:0] flat;
    addr_s           f;
  } addr_u;

  // access size of a core request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // controller sequence, also visible on the array interface
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    EVICT_REQ = 3'd2,
    EVICT     = 3'd3,
    FILL_REQ  = 3'd4,
    FILL      = 3'd5,
    RESPOND   = 3'd6
  } state_e;

  // byte lanes touched by an aligned access
  function automatic logic [3:0] size_to_be(size_e size, logic [1:0] lsb);
    logic [3:0] be;
    case (size)
      SIZE_BYTE: be = 4'b0001;
      SIZE_HALF: be = 4'b0011;
      default:   be = 4'b1111;
    endcase
    return be << lsb;
  endfunction

endpackage

`default_nettype wire

//--- src/dcache_array_if.sv
`default_nettype none

interface dcache_array_if #(
  parameter int NUM_WAYS = 2
);

  // lookup address of the current request
  logic [dcache_pkg::IDX_BITS-1:0]  idx;
  logic [dcache_pkg::TAG_BITS-1:0]  req_tag;
  logic [dcache_pkg::WORD_BITS-1:0] word;
  // one-hot way for all writes and the buffer load
  logic [NUM_WAYS-1:0]              way_sel;
  // tag, valid and dirty updates
  logic                             tag_we;
  logic                             dirty_we;
  logic                             dirty_val;
  // line buffer and data array control
  logic                             line_load;
  logic                             line_we;
  logic                             merge_en;
  logic [3:0]                       be;
  logic [dcache_pkg::XLEN-1:0]      wdata;
  dcache_pkg::state_e               state;

  // tag array results
  logic [NUM_WAYS-1:0]              hit;
  logic [NUM_WAYS-1:0]              victim;
  logic                             victim_dirty;
  logic [dcache_pkg::TAG_BITS-1:0]  victim_tag;

  // data array results
  logic [dcache_pkg::XLEN-1:0]      rdata;
  logic [dcache_pkg::XLEN-1:0]      line_word;

  modport ctrl (
    output idx, req_tag, word, way_sel, tag_we, dirty_we, dirty_val,
    output line_load, line_we, merge_en, be, wdata, state,
    input  hit, victim, victim_dirty, victim_tag
  );

  modport tag (
    input  idx, req_tag, way_sel, tag_we, dirty_we, dirty_val, state,
    output hit, victim, victim_dirty, victim_tag
  );

  modport data (
    input  idx, word, way_sel, line_load, line_we, merge_en, be, wdata,
    input  hit, state,
    output rdata, line_word
  );

endinterface

`default_nettype wire

//--- src/dcache_beat_cnt.sv
`default_nettype none

module dcache_beat_cnt (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  logic                             adv_i,
  input  logic                             abort_i,
  output logic [dcache_pkg::WORD_BITS-1:0] beat_idx_o,
  output logic                             last_o,
  output logic                             busy_o
);

  logic [dcache_pkg::WORD_BITS-1:0] cnt_q;
  logic                             busy_q;

  // final beat of a line, only while a burst is open
  assign last_o = busy_q & (cnt_q == dcache_pkg::WORD_BITS'(dcache_pkg::LINE_WORDS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (abort_i) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (start_i) begin
      cnt_q  <= '0;
      busy_q <= 1'b1;
    end else if (adv_i && busy_q) begin
      if (last_o) begin
        // back to zero so the next strobe shows the line base
        cnt_q  <= '0;
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign beat_idx_o = cnt_q;
  assign busy_o     = busy_q;

endmodule

`default_nettype wire

//--- src/dcache_tag_array.sv
`default_nettype none

module dcache_tag_array #(
  parameter int NUM_WAYS = 2
) (
  input logic         clk_i,
  input logic         rst_ni,
  dcache_array_if.tag arr
);

  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [dcache_pkg::TAG_BITS-1:0]           tag_mem [NUM_WAYS][dcache_pkg::SETS];
  logic [NUM_WAYS-1:0][dcache_pkg::SETS-1:0] valid_q;
  logic [NUM_WAYS-1:0][dcache_pkg::SETS-1:0] dirty_q;
  logic [dcache_pkg::IDX_BITS-1:0]           idx_q;
  logic [19:0]                               lfsr_q;
  logic [WAY_BITS-1:0]                       vic_idx;
  logic                                      miss_busy;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // tags carry no reset, valid and dirty start cleared
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr.tag_we && arr.way_sel[w]) begin
        tag_mem[w][arr.idx] <= arr.req_tag;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      idx_q   <= '0;
    end else begin
      idx_q <= arr.idx;
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (arr.tag_we && arr.way_sel[w]) begin
          valid_q[w][arr.idx] <= 1'b1;
        end
        if (arr.dirty_we && arr.way_sel[w]) begin
          dirty_q[w][arr.idx] <= arr.dirty_val;
        end
      end
    end
  end

  // results follow the index registered one cycle earlier
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      arr.hit[w] = valid_q[w][idx_q] & (tag_mem[w][idx_q] == arr.req_tag);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // victim choice
  //////////////////////////////////////////////////////////////////////

  // hold the random state still while a miss is on the bus
  assign miss_busy = (arr.state == dcache_pkg::EVICT_REQ) | (arr.state == dcache_pkg::EVICT) |
                     (arr.state == dcache_pkg::FILL_REQ)  | (arr.state == dcache_pkg::FILL);

  // x^20 + x^17 + 1 with xnor feedback, so all zero is a legal state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!miss_busy) begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
    end
  end

  // a direct mapped cache always picks way 0
  assign vic_idx          = (NUM_WAYS == 1) ? '0 : lfsr_q[WAY_BITS-1:0];
  assign arr.victim       = NUM_WAYS'(1) << vic_idx;
  assign arr.victim_dirty = dirty_q[vic_idx][idx_q];
  assign arr.victim_tag   = tag_mem[vic_idx][idx_q];

endmodule

`default_nettype wire

//--- src/dcache_data_array.sv
`default_nettype none

module dcache_data_array #(
  parameter int NUM_WAYS = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  dcache_array_if.data                     arr,
  input  logic [dcache_pkg::XLEN-1:0]      biu_rdata_i,
  input  logic                             biu_ack_i,
  input  logic [dcache_pkg::WORD_BITS-1:0] beat_idx_i,
  output logic [dcache_pkg::XLEN-1:0]      biu_wdata_o
);

  localparam int XLEN = dcache_pkg::XLEN;

  logic [dcache_pkg::LINE_BITS-1:0] line_mem [NUM_WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::LINE_BITS-1:0] line_buf_q;
  logic [dcache_pkg::LINE_BITS-1:0] hit_line;
  logic [dcache_pkg::LINE_BITS-1:0] sel_line;
  logic [dcache_pkg::LINE_BITS-1:0] fill_line;
  logic [dcache_pkg::IDX_BITS-1:0]  idx_q;

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      idx_q <= arr.idx;
    end
  end

  // and-or mux, hit way for the core, selected way for the buffer
  always_comb begin
    hit_line = '0;
    sel_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr.hit[w]) begin
        hit_line = hit_line | line_mem[w][idx_q];
      end
      if (arr.way_sel[w]) begin
        sel_line = sel_line | line_mem[w][idx_q];
      end
    end
  end

  assign arr.rdata = hit_line[arr.word*XLEN +: XLEN];

  //////////////////////////////////////////////////////////////////////
  // line buffer
  //////////////////////////////////////////////////////////////////////

  // eviction shifts word 0 out, fill drops each beat into its slot
  always_ff @(posedge clk_i) begin
    if (arr.line_load) begin
      line_buf_q <= sel_line;
    end else if (biu_ack_i && arr.state == dcache_pkg::EVICT) begin
      line_buf_q <= line_buf_q >> XLEN;
    end else if (biu_ack_i && arr.state == dcache_pkg::FILL) begin
      line_buf_q[beat_idx_i*XLEN +: XLEN] <= biu_rdata_i;
    end
  end

  assign arr.line_word = line_buf_q[XLEN-1:0];
  assign biu_wdata_o   = arr.line_word;

  // completed line, last beat taken straight from the bus
  always_comb begin
    fill_line                           = line_buf_q;
    fill_line[beat_idx_i*XLEN +: XLEN] = biu_rdata_i;
    for (int b = 0; b < 4; b++) begin
      if (arr.merge_en && arr.be[b]) begin
        fill_line[arr.word*XLEN + b*8 +: 8] = arr.wdata[b*8 +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // whole line at fill end, otherwise byte lanes of a write hit
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (arr.way_sel[w]) begin
        if (arr.line_we) begin
          line_mem[w][arr.idx] <= fill_line;
        end else if (arr.merge_en) begin
          for (int b = 0; b < 4; b++) begin
            if (arr.be[b]) begin
              line_mem[w][arr.idx][arr.word*XLEN + b*8 +: 8] <= arr.wdata[b*8 +: 8];
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dcache_ctrl_fsm.sv
`default_nettype none

module dcache_ctrl_fsm #(
  parameter int NUM_WAYS = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // core request side
  input  logic                             mem_req_i,
  input  logic [dcache_pkg::XLEN-1:0]      mem_addr_i,
  input  logic                             mem_we_i,
  input  dcache_pkg::size_e                mem_size_i,
  input  logic [dcache_pkg::XLEN-1:0]      mem_wdata_i,
  output logic                             mem_rdy_o,
  output logic                             mem_ack_o,
  output logic                             mem_err_o,

  // burst bus side
  output logic                             biu_stb_o,
  input  logic                             biu_stb_ack_i,
  output logic                             biu_we_o,
  output logic [dcache_pkg::XLEN-1:0]      biu_addr_o,
  input  logic                             biu_ack_i,
  input  logic                             biu_err_i,

  // beat counter
  output logic                             beat_start_o,
  input  logic                             beat_last_i,
  input  logic [dcache_pkg::WORD_BITS-1:0] beat_idx_i,

  dcache_array_if.ctrl                     arr
);

  dcache_pkg::state_e              state_q;
  dcache_pkg::state_e              state_d;
  dcache_pkg::addr_u               in_addr;
  dcache_pkg::addr_u               req_q;
  dcache_pkg::addr_u               bus_addr;
  logic                            we_q;
  logic                            err_q;
  logic [3:0]                      be_q;
  logic [dcache_pkg::XLEN-1:0]     wdata_q;
  logic [NUM_WAYS-1:0]             victim_q;
  logic [dcache_pkg::TAG_BITS-1:0] vtag_q;
  logic                            take;
  logic                            evicting;

  //////////////////////////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////////////////////////

  assign in_addr.flat = mem_addr_i;
  // only idle accepts, so ready is the idle flag
  assign mem_rdy_o    = (state_q == dcache_pkg::IDLE);
  assign take         = mem_rdy_o & mem_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= dcache_pkg::IDLE;
      we_q     <= 1'b0;
      err_q    <= 1'b0;
      victim_q <= '0;
    end else begin
      state_q <= state_d;
      if (take) begin
        we_q  <= mem_we_i;
        err_q <= 1'b0;
      end
      // victim is frozen here for the whole miss
      if (state_q == dcache_pkg::LOOKUP) begin
        victim_q <= arr.victim;
      end
      if (evicting && biu_err_i) begin
        err_q <= 1'b1;
      end
      if (state_q == dcache_pkg::FILL && biu_err_i) begin
        err_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      req_q   <= in_addr;
      be_q    <= dcache_pkg::size_to_be(mem_size_i, in_addr.f.byte_off);
      wdata_q <= mem_wdata_i;
    end
    if (state_q == dcache_pkg::LOOKUP) begin
      vtag_q <= arr.victim_tag;
    end
  end

  // arrays see the incoming index while idle so lookup has results
  assign arr.idx     = mem_rdy_o ? in_addr.f.idx : req_q.f.idx;
  assign arr.req_tag = req_q.f.tag;
  assign arr.word    = req_q.f.word;
  assign arr.be      = be_q;
  assign arr.wdata   = wdata_q;
  assign arr.state   = state_q;

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    beat_start_o  = 1'b0;
    arr.way_sel   = victim_q;
    arr.tag_we    = 1'b0;
    arr.dirty_we  = 1'b0;
    arr.dirty_val = 1'b0;
    arr.line_load = 1'b0;
    arr.line_we   = 1'b0;
    arr.merge_en  = 1'b0;
    case (state_q)
      dcache_pkg::IDLE: begin
        if (mem_req_i) begin
          state_d = dcache_pkg::LOOKUP;
        end
      end
      dcache_pkg::LOOKUP: begin
        if (|arr.hit) begin
          // write hit goes straight into the hit way and marks it dirty
          arr.way_sel   = arr.hit;
          arr.merge_en  = we_q;
          arr.dirty_we  = we_q;
          arr.dirty_val = 1'b1;
          state_d       = dcache_pkg::RESPOND;
        end else if (arr.victim_dirty) begin
          // copy the victim out before the fill overwrites it
          arr.way_sel   = arr.victim;
          arr.line_load = 1'b1;
          state_d       = dcache_pkg::EVICT_REQ;
        end else begin
          state_d = dcache_pkg::FILL_REQ;
        end
      end
      dcache_pkg::EVICT_REQ: begin
        if (biu_stb_ack_i) begin
          beat_start_o = 1'b1;
          state_d      = dcache_pkg::EVICT;
        end
      end
      dcache_pkg::EVICT: begin
        // an error leaves the victim dirty and skips the fill
        if (biu_err_i) begin
          state_d = dcache_pkg::RESPOND;
        end else if (biu_ack_i && beat_last_i) begin
          state_d = dcache_pkg::FILL_REQ;
        end
      end
      dcache_pkg::FILL_REQ: begin
        if (biu_stb_ack_i) begin
          beat_start_o = 1'b1;
          state_d      = dcache_pkg::FILL;
        end
      end
      dcache_pkg::FILL: begin
        if (biu_err_i) begin
          state_d = dcache_pkg::RESPOND;
        end else if (biu_ack_i && beat_last_i) begin
          // install tag, valid, dirty and the merged line together
          arr.tag_we    = 1'b1;
          arr.dirty_we  = 1'b1;
          arr.dirty_val = we_q;
          arr.line_we   = 1'b1;
          arr.merge_en  = we_q;
          state_d       = dcache_pkg::RESPOND;
        end
      end
      dcache_pkg::RESPOND: begin
        state_d = dcache_pkg::IDLE;
      end
      default: begin
        state_d = dcache_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // bus and core outputs
  //////////////////////////////////////////////////////////////////////

  assign evicting = (state_q == dcache_pkg::EVICT_REQ) | (state_q == dcache_pkg::EVICT);

  // line base while strobing, then the running beat address
  always_comb begin
    bus_addr.f.tag      = evicting ? vtag_q : req_q.f.tag;
    bus_addr.f.idx      = req_q.f.idx;
    bus_addr.f.word     = beat_idx_i;
    bus_addr.f.byte_off = 2'b00;
  end

  assign biu_addr_o = bus_addr.flat;
  assign biu_stb_o  = (state_q == dcache_pkg::EVICT_REQ) | (state_q == dcache_pkg::FILL_REQ);
  assign biu_we_o   = evicting;
  assign mem_ack_o  = (state_q == dcache_pkg::RESPOND);
  assign mem_err_o  = mem_ack_o & err_q;

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`default_nettype none

module dcache_top #(
  parameter int NUM_WAYS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // core side
  input  logic                        mem_req_i,
  input  logic [dcache_pkg::XLEN-1:0] mem_addr_i,
  input  logic                        mem_we_i,
  input  dcache_pkg::size_e           mem_size_i,
  input  logic [dcache_pkg::XLEN-1:0] mem_wdata_i,
  output logic                        mem_rdy_o,
  output logic                        mem_ack_o,
  output logic                        mem_err_o,
  output logic [dcache_pkg::XLEN-1:0] mem_rdata_o,

  // bus side
  output logic                        biu_stb_o,
  input  logic                        biu_stb_ack_i,
  output logic                        biu_we_o,
  output logic [dcache_pkg::XLEN-1:0] biu_addr_o,
  output logic [dcache_pkg::XLEN-1:0] biu_wdata_o,
  input  logic [dcache_pkg::XLEN-1:0] biu_rdata_i,
  input  logic                        biu_ack_i,
  input  logic                        biu_err_i
);

  logic                             beat_start;
  logic                             beat_last;
  logic [dcache_pkg::WORD_BITS-1:0] beat_idx;

  dcache_array_if #(.NUM_WAYS(NUM_WAYS)) arr_if ();

  dcache_ctrl_fsm #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req_i),
    .mem_addr_i   (mem_addr_i),
    .mem_we_i     (mem_we_i),
    .mem_size_i   (mem_size_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_rdy_o    (mem_rdy_o),
    .mem_ack_o    (mem_ack_o),
    .mem_err_o    (mem_err_o),
    .biu_stb_o    (biu_stb_o),
    .biu_stb_ack_i(biu_stb_ack_i),
    .biu_we_o     (biu_we_o),
    .biu_addr_o   (biu_addr_o),
    .biu_ack_i    (biu_ack_i),
    .biu_err_i    (biu_err_i),
    .beat_start_o (beat_start),
    .beat_last_i  (beat_last),
    .beat_idx_i   (beat_idx),
    .arr          (arr_if)
  );

  // beats advance on each bus ack, an error closes the burst
  dcache_beat_cnt u_beat (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (beat_start),
    .adv_i     (biu_ack_i),
    .abort_i   (biu_err_i),
    .beat_idx_o(beat_idx),
    .last_o    (beat_last),
    .busy_o    ()
  );

  dcache_tag_array #(.NUM_WAYS(NUM_WAYS)) u_tag (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .arr   (arr_if)
  );

  dcache_data_array #(.NUM_WAYS(NUM_WAYS)) u_data (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .arr        (arr_if),
    .biu_rdata_i(biu_rdata_i),
    .biu_ack_i  (biu_ack_i),
    .beat_idx_i (beat_idx),
    .biu_wdata_o(biu_wdata_o)
  );

  // hit way word, valid while the ack is high
  assign mem_rdata_o = arr_if.rdata;

endmodule

`default_nettype wire

//--- bench/tb_bus_mem.sv
`default_nettype none

module tb_bus_mem #(
  parameter int          WORDS    = 4096,
  parameter logic [31:0] ERR_BASE = 32'h0000_3000,
  parameter int          DRV      = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stall_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        stb_ack_o,
  output logic [31:0] rdata_o,
  output logic        ack_o,
  output logic        err_o
);

  logic [31:0] mem [WORDS];
  logic [31:0] base;
  logic        we;
  logic [11:0] waddr;
  int          hold;

  // odd multiplier, so every address bit shows up in the word
  function automatic logic [31:0] init_word(int i);
    return 32'(i) * 32'h9E37_79B1 + 32'h1234_5678;
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = init_word(i);
    end
    stb_ack_o = 1'b0;
    rdata_o   = '0;
    ack_o     = 1'b0;
    err_o     = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // burst server
  //////////////////////////////////////////////////////////////////////

  // sampled on the falling edge, driven just after the rising edge
  always begin : serve
    @(negedge clk_i);
    if (rst_ni && stb_i) begin
      // back-pressure, bounded so a stuck stall cannot hold the bus
      hold = 0;
      while (stall_i && hold < 16) begin
        hold++;
        @(negedge clk_i);
      end
      base = addr_i;
      we   = we_i;
      @(posedge clk_i);
      #DRV stb_ack_o = 1'b1;
      @(posedge clk_i);
      #DRV stb_ack_o = 1'b0;
      if (base[31:4] == ERR_BASE[31:4]) begin
        // poisoned line, the first beat ends the burst
        err_o = 1'b1;
        @(posedge clk_i);
        #DRV err_o = 1'b0;
      end else begin
        // linear beats from the line base, one ack each
        ack_o = 1'b1;
        for (int b = 0; b < 4; b++) begin
          waddr   = {base[13:4], 2'(b)};
          rdata_o = mem[waddr];
          @(negedge clk_i);
          if (we) begin
            mem[waddr] = wdata_i;
          end
          @(posedge clk_i);
          #DRV;
        end
        ack_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_dcache.sv
`default_nettype none

module tb_dcache;

  localparam int          NUM_WAYS  = 2;
  localparam int          MEM_WORDS = 4096;
  localparam int          TIMEOUT   = 200;
  localparam int          DRV       = 2;
  localparam logic [31:0] ERR_ADDR  = 32'h0000_3000;

  logic               clk_i;
  logic               rst_ni;
  logic               mem_req_i;
  logic [31:0]        mem_addr_i;
  logic               mem_we_i;
  dcache_pkg::size_e  mem_size_i;
  logic [31:0]        mem_wdata_i;
  logic               mem_rdy_o;
  logic               mem_ack_o;
  logic               mem_err_o;
  logic [31:0]        mem_rdata_o;
  logic               biu_stb_o;
  logic               biu_stb_ack_i;
  logic               biu_we_o;
  logic [31:0]        biu_addr_o;
  logic [31:0]        biu_wdata_o;
  logic [31:0]        biu_rdata_i;
  logic               biu_ack_i;
  logic               biu_err_i;
  logic               stall;
  logic               stall_en;

  // expected answer of the request in flight
  string              cur_name;
  logic               pending;
  logic               exp_err;
  logic               chk_data;
  logic [31:0]        exp_data;

  logic [31:0]        shadow [MEM_WORDS];
  logic [31:0]        lcg_state;
  logic [31:0]        stall_state;

  dcache_top #(.NUM_WAYS(NUM_WAYS)) DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req_i),
    .mem_addr_i   (mem_addr_i),
    .mem_we_i     (mem_we_i),
    .mem_size_i   (mem_size_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_rdy_o    (mem_rdy_o),
    .mem_ack_o    (mem_ack_o),
    .mem_err_o    (mem_err_o),
    .mem_rdata_o  (mem_rdata_o),
    .biu_stb_o    (biu_stb_o),
    .biu_stb_ack_i(biu_stb_ack_i),
    .biu_we_o     (biu_we_o),
    .biu_addr_o   (biu_addr_o),
    .biu_wdata_o  (biu_wdata_o),
    .biu_rdata_i  (biu_rdata_i),
    .biu_ack_i    (biu_ack_i),
    .biu_err_i    (biu_err_i)
  );

  tb_bus_mem #(.WORDS(MEM_WORDS), .ERR_BASE(ERR_ADDR), .DRV(DRV)) u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stall_i  (stall),
    .stb_i    (biu_stb_o),
    .we_i     (biu_we_o),
    .addr_i   (biu_addr_o),
    .wdata_i  (biu_wdata_o),
    .stb_ack_o(biu_stb_ack_i),
    .rdata_o  (biu_rdata_i),
    .ack_o    (biu_ack_i),
    .err_o    (biu_err_i)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // same content the bus memory starts with
  function automatic logic [31:0] init_word(int i);
    return 32'(i) * 32'h9E37_79B1 + 32'h1234_5678;
  endfunction

  // word held after the access, lanes from lsb up to the access size
  function automatic logic [31:0] expected_word(logic [31:0] addr, logic we,
                                                logic [1:0] size, logic [31:0] wdata);
    logic [31:0] res;
    int          count;
    res   = shadow[addr[13:2]];
    count = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (b >= int'(addr[1:0]) && b < int'(addr[1:0]) + count) begin
          res[b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    return res;
  endfunction

  // four sets that all the random traffic piles into
  function automatic logic [5:0] hot_set(logic [1:0] k);
    case (k)
      2'd0:    return 6'd3;
      2'd1:    return 6'd17;
      2'd2:    return 6'd40;
      default: return 6'd63;
    endcase
  endfunction

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // one core request, returns cycles from request to ack
  task automatic run_access(input string name, input logic [31:0] addr, input logic we,
                            input logic [1:0] size, input logic [31:0] wdata,
                            input logic err, output int lat);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!mem_rdy_o) begin
      n++;
      if (n > TIMEOUT) begin
        stop_on_failure("cache never became ready for a new request");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DRV;
    exp_data    = expected_word(addr, we, size, wdata);
    exp_err     = err;
    chk_data    = !we && !err;
    cur_name    = name;
    pending     = 1'b1;
    if (we && !err) begin
      shadow[addr[13:2]] = exp_data;
    end
    mem_req_i   = 1'b1;
    mem_addr_i  = addr;
    mem_we_i    = we;
    mem_size_i  = dcache_pkg::size_e'(size);
    mem_wdata_i = wdata;
    @(posedge clk_i);
    #DRV;
    mem_req_i = 1'b0;
    lat = 1;
    @(negedge clk_i);
    while (!mem_ack_o) begin
      lat++;
      if (lat > TIMEOUT) begin
        stop_on_failure("no acknowledge came back for a core request");
      end
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checker and random back-pressure
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && mem_ack_o) begin
      assert (pending) else begin
        stop_on_failure("acknowledge seen with no request outstanding");
      end
      assert (mem_err_o == exp_err) else begin
        stop_on_failure($sformatf("ERR %s err expected %0b actual %0b",
                                  cur_name, exp_err, mem_err_o));
      end
      if (chk_data) begin
        assert (mem_rdata_o == exp_data) else begin
          stop_on_failure($sformatf("ERR %s expected %h actual %h",
                                    cur_name, exp_data, mem_rdata_o));
        end
      end
      pending = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    #DRV;
    stall_state = lcg_next(stall_state);
    stall       = stall_en & stall_state[16];
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [15:0] r;
    logic [31:0] wd;
    logic [31:0] addr;
    logic [1:0]  sz;
    logic [1:0]  lsb;
    int          lat;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    mem_req_i   = 1'b0;
    mem_addr_i  = '0;
    mem_we_i    = 1'b0;
    mem_size_i  = dcache_pkg::SIZE_WORD;
    mem_wdata_i = '0;
    stall       = 1'b0;
    stall_en    = 1'b0;
    pending     = 1'b0;
    exp_err     = 1'b0;
    chk_data    = 1'b0;
    exp_data    = '0;
    cur_name    = "reset";
    lcg_state   = 32'd85878;
    stall_state = 32'd85878;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = init_word(i);
    end
    repeat (5) @(posedge clk_i);
    #DRV rst_ni = 1'b1;

    // idle outputs once reset is gone
    @(negedge clk_i);
    assert (mem_rdy_o && !biu_stb_o && !mem_ack_o) else begin
      stop_on_failure("ready, strobe or ack wrong after reset");
    end

    // cold miss, then a hit in the same line with fixed latency
    run_access("read_miss", 32'h0000_0040, 1'b0, 2'd2, '0, 1'b0, lat);
    run_access("read_hit", 32'h0000_0044, 1'b0, 2'd2, '0, 1'b0, lat);
    assert (lat == 2) else begin
      stop_on_failure($sformatf("ERR read_hit_latency expected %0d actual %0d", 2, lat));
    end

    // every size into the cached line, then read it back
    run_access("write_byte", 32'h0000_0041, 1'b1, 2'd0, 32'hA5A5_A5A5, 1'b0, lat);
    run_access("write_half", 32'h0000_0046, 1'b1, 2'd1, 32'h1234_5678, 1'b0, lat);
    run_access("write_word", 32'h0000_0048, 1'b1, 2'd2, 32'hDEAD_BEEF, 1'b0, lat);
    run_access("write_top_byte", 32'h0000_004F, 1'b1, 2'd0, 32'h7700_0000, 1'b0, lat);
    for (int w = 0; w < 4; w++) begin
      run_access("read_merged", 32'h0000_0040 + 32'(w * 4), 1'b0, 2'd2, '0, 1'b0, lat);
    end

    // 8 tags over 4 sets and 2 ways, second half with back-pressure
    for (int k = 0; k < 300; k++) begin
      if (k == 150) begin
        stall_en = 1'b1;
      end
      lcg_state = lcg_next(lcg_state);
      r         = lcg_state[31:16];
      lcg_state = lcg_next(lcg_state);
      wd        = lcg_state;
      sz        = (r[9:8] == 2'd3) ? 2'd2 : r[9:8];
      lsb       = (sz == 2'd0) ? r[11:10] : (sz == 2'd1) ? {r[10], 1'b0} : 2'b00;
      addr      = {19'd0, r[4:2], hot_set(r[1:0]), r[6:5], lsb};
      run_access("random", addr, r[7], sz, wd, 1'b0, lat);
    end

    // bus error on the poisoned line, then everything still reads back
    run_access("error_read", ERR_ADDR, 1'b0, 2'd2, '0, 1'b1, lat);
    for (int s = 0; s < 4; s++) begin
      for (int t = 0; t < 8; t++) begin
        for (int w = 0; w < 4; w++) begin
          addr = {19'd0, 3'(t), hot_set(2'(s)), 2'(w), 2'b00};
          run_access("sweep", addr, 1'b0, 2'd2, '0, 1'b0, lat);
        end
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/dcache_pkg.sv
src/dcache_array_if.sv
src/dcache_beat_cnt.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl_fsm.sv
src/dcache_top.sv
bench/tb_bus_mem.sv
bench/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dcache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
